//--- filelist.f
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/pipe_ifs.sv
hw/decode_stage.sv
hw/id_ex_buffer.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_core.sv
sim/cpu_core_tb.sv

//--- hw/cpu_core.sv
`timescale 1ns/10ps
// decode/execute/result core of the 32-bit pipeline
// instruction fed from outside, data memory on plain ports

module cpu_core (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               stall,
   input  logic [cpu_isa_pkg::xlen-1:0]       instruction,
   input  logic [cpu_isa_pkg::xlen-1:0]       mem_rdata,
   output logic                               mem_cs_n,
   output logic                               mem_we,
   output logic [cpu_isa_pkg::xlen-1:0]       mem_addr,
   output logic [cpu_isa_pkg::xlen-1:0]       mem_wdata,
   output logic                               wb_we,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] wb_addr,
   output logic [cpu_isa_pkg::xlen-1:0]       wb_data
);
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;

   logic [wb_ctrl_w-1:0]  wb_ctrl;
   logic [mem_ctrl_w-1:0] mem_ctrl;
   logic [ex_ctrl_w-1:0]  ex_ctrl;
   logic [xlen-1:0]       r_data_0;
   logic [xlen-1:0]       r_data_1;

   id_ex_if  id_ex ();
   ex_res_if ex_res ();

   decode_stage u_decode (
      .clk, .rst, .instruction,
      .rf_we(wb_we), .rf_waddr(wb_addr), .rf_wdata(wb_data),
      .wb_ctrl, .mem_ctrl, .ex_ctrl, .r_data_0, .r_data_1
   );

   id_ex_buffer u_buffer (
      .clk, .rst, .stall,
      .wb_ctrl, .mem_ctrl, .ex_ctrl, .r_data_0, .r_data_1, .instruction,
      .rf_we(wb_we), .rf_waddr(wb_addr), .rf_wdata(wb_data),
      .id_ex(id_ex.src)
   );

   // forward path is the register-file write port
   execute_stage u_execute (
      .id_ex(id_ex.dst),
      .fwd_we(wb_we), .fwd_rd(wb_addr), .fwd_data(wb_data),
      .ex_res(ex_res.src)
   );

   result_stage u_result (
      .clk, .rst, .ex_res(ex_res.dst), .mem_rdata,
      .mem_cs_n, .mem_we, .mem_addr, .mem_wdata,
      .rf_we(wb_we), .rf_waddr(wb_addr), .rf_wdata(wb_data)
   );

endmodule

//--- hw/cpu_ctrl_pkg.sv
// pipeline control field layouts and ALU operation codes
// bubble values make a stage do nothing
package cpu_ctrl_pkg;

   // writeback field, active low bits
   localparam int wb_ctrl_w     = 3;
   localparam int wb_rf_we_n    = 0;
   localparam int wb_from_mem_n = 1;  // bit 2 reserved
   localparam logic [wb_ctrl_w-1:0] wb_bubble = 3'b011;  // no write
   localparam logic [wb_ctrl_w-1:0] wb_alu    = 3'b010;  // write alu result
   localparam logic [wb_ctrl_w-1:0] wb_load   = 3'b000;  // write load data

   // memory field
   localparam int mem_ctrl_w   = 3;
   localparam int mem_cs_n_bit = 2;
   localparam int mem_we_bit   = 1;  // bit 0 reserved
   localparam logic [mem_ctrl_w-1:0] mem_bubble = 3'b100;  // cs high, disabled
   localparam logic [mem_ctrl_w-1:0] mem_read   = 3'b000;
   localparam logic [mem_ctrl_w-1:0] mem_write  = 3'b010;

   // execute field {alu_op, imm_sel, imm_sign, uses_a, uses_b}
   localparam int ex_ctrl_w   = 7;
   localparam int alu_w       = 3;
   localparam int ex_alu_lo   = 4;
   localparam int ex_imm_sel  = 3;
   localparam int ex_imm_sign = 2;
   localparam int ex_uses_a   = 1;
   localparam int ex_uses_b   = 0;
   localparam logic [ex_ctrl_w-1:0] ex_bubble = '0;

   localparam logic [alu_w-1:0] alu_add = 3'd0;
   localparam logic [alu_w-1:0] alu_sub = 3'd1;
   localparam logic [alu_w-1:0] alu_and = 3'd2;
   localparam logic [alu_w-1:0] alu_or  = 3'd3;
   localparam logic [alu_w-1:0] alu_xor = 3'd4;
   localparam logic [alu_w-1:0] alu_slt = 3'd5;  // signed compare

endpackage

//--- hw/cpu_isa_pkg.sv
// instruction set definitions for the 32-bit core
// word width, register file size, field positions and opcodes
package cpu_isa_pkg;

   localparam int xlen       = 32;
   localparam int reg_count  = 32;
   localparam int reg_addr_w = 5;

   // instruction fields, low bit and width
   localparam int op_w  = 6;
   localparam int op_lo = 26;  // opcode 31..26
   localparam int rd_lo = 21;  // rd 25..21
   localparam int rs_lo = 16;  // rs 20..16
   localparam int rt_lo = 11;  // rt 15..11
   localparam int imm_w = 16;  // imm16 15..0

   localparam logic [op_w-1:0] op_nop  = 6'd0;
   localparam logic [op_w-1:0] op_add  = 6'd1;
   localparam logic [op_w-1:0] op_sub  = 6'd2;
   localparam logic [op_w-1:0] op_and  = 6'd3;
   localparam logic [op_w-1:0] op_or   = 6'd4;
   localparam logic [op_w-1:0] op_xor  = 6'd5;
   localparam logic [op_w-1:0] op_slt  = 6'd6;
   localparam logic [op_w-1:0] op_addi = 6'd7;  // rd = rs + sext(imm)
   localparam logic [op_w-1:0] op_lw   = 6'd8;  // rd = mem[rs + sext(imm)]
   localparam logic [op_w-1:0] op_sw   = 6'd9;  // mem[rs + sext(imm)] = rd

endpackage

//--- hw/decode_stage.sv
`timescale 1ns/10ps
// instruction decode
// register file with write bypass and control field generation

module decode_stage (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [cpu_isa_pkg::xlen-1:0]        instruction,
   input  logic                                rf_we,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rf_waddr,
   input  logic [cpu_isa_pkg::xlen-1:0]        rf_wdata,
   output logic [cpu_ctrl_pkg::wb_ctrl_w-1:0]  wb_ctrl,
   output logic [cpu_ctrl_pkg::mem_ctrl_w-1:0] mem_ctrl,
   output logic [cpu_ctrl_pkg::ex_ctrl_w-1:0]  ex_ctrl,
   output logic [cpu_isa_pkg::xlen-1:0]        r_data_0,
   output logic [cpu_isa_pkg::xlen-1:0]        r_data_1
);
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;

   logic [xlen-1:0]       regs [reg_count];  // entry 0 never written
   logic [op_w-1:0]       opcode;
   logic [reg_addr_w-1:0] rs_addr;
   logic [reg_addr_w-1:0] rb_addr;
   logic [alu_w-1:0]      reg_alu_op;

   assign opcode  = instruction[op_lo +: op_w];
   assign rs_addr = instruction[rs_lo +: reg_addr_w];
   // second port reads rd for stores, rt otherwise
   assign rb_addr = (opcode == op_sw) ? instruction[rd_lo +: reg_addr_w]
                                      : instruction[rt_lo +: reg_addr_w];

   assign r_data_0 = (rs_addr == '0) ? '0 :
                     (rf_we && rf_waddr == rs_addr) ? rf_wdata : regs[rs_addr];
   assign r_data_1 = (rb_addr == '0) ? '0 :
                     (rf_we && rf_waddr == rb_addr) ? rf_wdata : regs[rb_addr];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_we && rf_waddr != '0) begin
         regs[rf_waddr] <= rf_wdata;
      end
   end

   always_comb begin
      case (opcode)
         op_sub:  reg_alu_op = alu_sub;
         op_and:  reg_alu_op = alu_and;
         op_or:   reg_alu_op = alu_or;
         op_xor:  reg_alu_op = alu_xor;
         op_slt:  reg_alu_op = alu_slt;
         default: reg_alu_op = alu_add;
      endcase
   end

   // ex_ctrl = {alu_op, imm_sel, imm_sign, uses_a, uses_b}
   always_comb begin
      wb_ctrl  = wb_bubble;
      mem_ctrl = mem_bubble;
      ex_ctrl  = ex_bubble;
      case (opcode)
         op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
            wb_ctrl = wb_alu;
            ex_ctrl = {reg_alu_op, 1'b0, 1'b0, 1'b1, 1'b1};
         end
         op_addi: begin
            wb_ctrl = wb_alu;
            ex_ctrl = {alu_add, 1'b1, 1'b1, 1'b1, 1'b0};
         end
         op_lw: begin
            wb_ctrl  = wb_load;
            mem_ctrl = mem_read;
            ex_ctrl  = {alu_add, 1'b1, 1'b1, 1'b1, 1'b0};
         end
         op_sw: begin
            mem_ctrl = mem_write;
            ex_ctrl  = {alu_add, 1'b1, 1'b1, 1'b1, 1'b1};  // b carries store data
         end
         default: begin
            ex_ctrl = ex_bubble;  // nop and unknown opcodes
         end
      endcase
   end

   // result stage must never commit a write to r0
   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst)
      rf_we |-> rf_waddr != '0)
      else $error("decode: register 0 write requested");

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/10ps
// execute stage
// operand forwarding from the result stage, immediate extension, ALU

module execute_stage (
   id_ex_if.dst                               id_ex,
   input  logic                               fwd_we,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0] fwd_rd,
   input  logic [cpu_isa_pkg::xlen-1:0]       fwd_data,
   ex_res_if.src                              ex_res
);
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;

   logic [reg_addr_w-1:0] rs_addr;
   logic [reg_addr_w-1:0] rb_addr;
   logic [imm_w-1:0]      imm;
   logic [alu_w-1:0]      alu_op;
   logic                  fwd_a;
   logic                  fwd_b;
   logic [xlen-1:0]       op_a;
   logic [xlen-1:0]       reg_b;
   logic [xlen-1:0]       imm_ext;
   logic [xlen-1:0]       op_b;

   assign rs_addr = id_ex.instruction[rs_lo +: reg_addr_w];
   assign rb_addr = (id_ex.instruction[op_lo +: op_w] == op_sw) ?
                    id_ex.instruction[rd_lo +: reg_addr_w] :
                    id_ex.instruction[rt_lo +: reg_addr_w];
   assign imm     = id_ex.instruction[0 +: imm_w];
   assign alu_op  = id_ex.ex_ctrl[ex_alu_lo +: alu_w];

   // only operands the instruction really reads take the forward
   assign fwd_a = id_ex.ex_ctrl[ex_uses_a] && fwd_we && fwd_rd != '0 && fwd_rd == rs_addr;
   assign fwd_b = id_ex.ex_ctrl[ex_uses_b] && fwd_we && fwd_rd != '0 && fwd_rd == rb_addr;

   assign op_a    = fwd_a ? fwd_data : id_ex.r_data_0;
   assign reg_b   = fwd_b ? fwd_data : id_ex.r_data_1;
   assign imm_ext = id_ex.ex_ctrl[ex_imm_sign] ? {{(xlen-imm_w){imm[imm_w-1]}}, imm}
                                               : {{(xlen-imm_w){1'b0}}, imm};
   assign op_b    = id_ex.ex_ctrl[ex_imm_sel] ? imm_ext : reg_b;

   always_comb begin
      case (alu_op)
         alu_add: ex_res.alu_result = op_a + op_b;
         alu_sub: ex_res.alu_result = op_a - op_b;
         alu_and: ex_res.alu_result = op_a & op_b;
         alu_or:  ex_res.alu_result = op_a | op_b;
         alu_xor: ex_res.alu_result = op_a ^ op_b;
         alu_slt: ex_res.alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: ex_res.alu_result = '0;
      endcase
   end

   assign ex_res.wb_ctrl    = id_ex.wb_ctrl;
   assign ex_res.mem_ctrl   = id_ex.mem_ctrl;
   assign ex_res.store_data = reg_b;  // rd value for stores
   assign ex_res.rd         = id_ex.instruction[rd_lo +: reg_addr_w];

   // decode only emits defined alu codes for live instructions
   always_comb begin
      if (id_ex.ex_ctrl != ex_bubble) begin
         a_alu_op_known: assert (alu_op inside {alu_add, alu_sub, alu_and,
                                               alu_or, alu_xor, alu_slt})
            else $error("execute: undefined alu_op %0d", alu_op);
      end
   end

endmodule

//--- hw/id_ex_buffer.sv
`timescale 1ns/10ps
// ID/EX buffer between decode and execute
// holds its entry across a stall and shows a bubble meanwhile

module id_ex_buffer (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                stall,
   input  logic [cpu_ctrl_pkg::wb_ctrl_w-1:0]  wb_ctrl,
   input  logic [cpu_ctrl_pkg::mem_ctrl_w-1:0] mem_ctrl,
   input  logic [cpu_ctrl_pkg::ex_ctrl_w-1:0]  ex_ctrl,
   input  logic [cpu_isa_pkg::xlen-1:0]        r_data_0,
   input  logic [cpu_isa_pkg::xlen-1:0]        r_data_1,
   input  logic [cpu_isa_pkg::xlen-1:0]        instruction,
   input  logic                                rf_we,
   input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rf_waddr,
   input  logic [cpu_isa_pkg::xlen-1:0]        rf_wdata,
   id_ex_if.src                                id_ex
);
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;

   localparam logic [xlen-1:0] nop_word = {op_nop, {(xlen-op_w){1'b0}}};

   logic [wb_ctrl_w-1:0]  wb_ctrl_saved;
   logic [mem_ctrl_w-1:0] mem_ctrl_saved;
   logic [ex_ctrl_w-1:0]  ex_ctrl_saved;
   logic [xlen-1:0]       r_data_0_saved;
   logic [xlen-1:0]       r_data_1_saved;
   logic [xlen-1:0]       instruction_saved;
   logic [reg_addr_w-1:0] held_rs;
   logic [reg_addr_w-1:0] held_rb;

   // source registers of the held entry, same choice as decode
   assign held_rs = instruction_saved[rs_lo +: reg_addr_w];
   assign held_rb = (instruction_saved[op_lo +: op_w] == op_sw) ?
                    instruction_saved[rd_lo +: reg_addr_w] :
                    instruction_saved[rt_lo +: reg_addr_w];

   assign id_ex.wb_ctrl     = stall ? wb_bubble  : wb_ctrl_saved;
   assign id_ex.mem_ctrl    = stall ? mem_bubble : mem_ctrl_saved;
   assign id_ex.ex_ctrl     = stall ? ex_bubble  : ex_ctrl_saved;
   assign id_ex.instruction = stall ? nop_word   : instruction_saved;
   assign id_ex.r_data_0    = r_data_0_saved;
   assign id_ex.r_data_1    = r_data_1_saved;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb_ctrl_saved     <= wb_bubble;
         mem_ctrl_saved    <= mem_bubble;
         ex_ctrl_saved     <= ex_bubble;
         instruction_saved <= nop_word;
      end else if (!stall) begin
         wb_ctrl_saved     <= wb_ctrl;
         mem_ctrl_saved    <= mem_ctrl;
         ex_ctrl_saved     <= ex_ctrl;
         instruction_saved <= instruction;
      end
   end

   // a write retiring during a stall would be missed by forwarding later
   always_ff @(posedge clk) begin
      if (!stall) begin
         r_data_0_saved <= r_data_0;
         r_data_1_saved <= r_data_1;
      end else begin
         if (rf_we && rf_waddr == held_rs) r_data_0_saved <= rf_wdata;
         if (rf_we && rf_waddr == held_rb) r_data_1_saved <= rf_wdata;
      end
   end

   // bubble shown now, held entry untouched for the retry
   a_stall_bubble: assert property (@(posedge clk) disable iff (!rst)
      stall |-> (id_ex.wb_ctrl == wb_bubble && id_ex.mem_ctrl == mem_bubble &&
                 id_ex.ex_ctrl == ex_bubble) ##1 (ex_ctrl_saved == $past(ex_ctrl_saved)))
      else $error("id_ex_buffer: stall did not present a held bubble");

endmodule

//--- hw/pipe_ifs.sv
`timescale 1ns/10ps
// pipeline links inside the core
// id_ex_if leaves the ID/EX buffer, ex_res_if feeds the result register

interface id_ex_if;
   logic [cpu_ctrl_pkg::wb_ctrl_w-1:0]  wb_ctrl;
   logic [cpu_ctrl_pkg::mem_ctrl_w-1:0] mem_ctrl;
   logic [cpu_ctrl_pkg::ex_ctrl_w-1:0]  ex_ctrl;
   logic [cpu_isa_pkg::xlen-1:0]        r_data_0;
   logic [cpu_isa_pkg::xlen-1:0]        r_data_1;
   logic [cpu_isa_pkg::xlen-1:0]        instruction;

   modport src (output wb_ctrl, mem_ctrl, ex_ctrl, r_data_0, r_data_1, instruction);
   modport dst (input wb_ctrl, mem_ctrl, ex_ctrl, r_data_0, r_data_1, instruction);
endinterface

interface ex_res_if;
   logic [cpu_ctrl_pkg::wb_ctrl_w-1:0]  wb_ctrl;
   logic [cpu_ctrl_pkg::mem_ctrl_w-1:0] mem_ctrl;
   logic [cpu_isa_pkg::xlen-1:0]        alu_result;
   logic [cpu_isa_pkg::xlen-1:0]        store_data;
   logic [cpu_isa_pkg::reg_addr_w-1:0]  rd;

   modport src (output wb_ctrl, mem_ctrl, alu_result, store_data, rd);
   modport dst (input wb_ctrl, mem_ctrl, alu_result, store_data, rd);
endinterface

//--- hw/result_stage.sv
`timescale 1ns/10ps
// result stage
// EX/result register, data memory port and writeback select

module result_stage (
   input  logic                               clk,
   input  logic                               rst,
   ex_res_if.dst                              ex_res,
   input  logic [cpu_isa_pkg::xlen-1:0]       mem_rdata,
   output logic                               mem_cs_n,
   output logic                               mem_we,
   output logic [cpu_isa_pkg::xlen-1:0]       mem_addr,
   output logic [cpu_isa_pkg::xlen-1:0]       mem_wdata,
   output logic                               rf_we,
   output logic [cpu_isa_pkg::reg_addr_w-1:0] rf_waddr,
   output logic [cpu_isa_pkg::xlen-1:0]       rf_wdata
);
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;

   logic [wb_ctrl_w-1:0]  wb_ctrl_q;
   logic [mem_ctrl_w-1:0] mem_ctrl_q;
   logic [xlen-1:0]       alu_result_q;
   logic [xlen-1:0]       store_data_q;
   logic [reg_addr_w-1:0] rd_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb_ctrl_q  <= wb_bubble;
         mem_ctrl_q <= mem_bubble;
      end else begin
         wb_ctrl_q  <= ex_res.wb_ctrl;
         mem_ctrl_q <= ex_res.mem_ctrl;
      end
   end

   always_ff @(posedge clk) begin
      alu_result_q <= ex_res.alu_result;
      store_data_q <= ex_res.store_data;
      rd_q         <= ex_res.rd;
   end

   assign mem_cs_n  = mem_ctrl_q[mem_cs_n_bit];
   assign mem_we    = mem_ctrl_q[mem_we_bit];
   assign mem_addr  = alu_result_q;  // rs + imm
   assign mem_wdata = store_data_q;

   assign rf_we    = !wb_ctrl_q[wb_rf_we_n] && rd_q != '0;
   assign rf_waddr = rd_q;
   assign rf_wdata = wb_ctrl_q[wb_from_mem_n] ? alu_result_q : mem_rdata;

   a_we_needs_cs: assert property (@(posedge clk) disable iff (!rst)
      mem_cs_n |-> !mem_we)
      else $error("result: write enable without chip select");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 -f filelist.f \
   --top-module cpu_core_tb -Mdir "$build_dir" -o cpu_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/cpu_core_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qF '*** FAILED ***' "$log_file"; then
   exit 1
fi
exit 0

//--- sim/cpu_core_tb.sv
`timescale 1ns/10ps
// testbench for cpu_core
// random program with random stalls, reference register and memory model,
// concurrent assertions on writeback and memory traffic

module cpu_core_tb;
   import cpu_isa_pkg::*;

   localparam int clk_period      = 100;
   localparam int drive_delay     = 10;
   localparam int n_instr         = 300;
   localparam int drain_cycles    = 4;
   localparam int watchdog_cycles = n_instr * 2 + 40;  // reset and drain margin

   logic        clk = 1'b0;
   logic        rst;
   logic        stall;
   logic [31:0] instruction;
   logic [31:0] mem_rdata;
   logic        mem_cs_n;
   logic        mem_we;
   logic [31:0] mem_addr;
   logic [31:0] mem_wdata;
   logic        wb_we;
   logic [4:0]  wb_addr;
   logic [31:0] wb_data;

   logic [31:0] data_mem [256];  // external memory, word index addr[9:2]
   logic [31:0] model_mem [256];
   logic [31:0] model_regs [32];

   logic [4:0]  exp_wb_addr [$];
   logic [31:0] exp_wb_data [$];
   logic [31:0] exp_mem_addr [$];
   logic        exp_mem_we [$];
   logic [31:0] exp_mem_wdata [$];

   logic        head_wb_valid = 1'b0;
   logic [4:0]  head_wb_addr = '0;
   logic [31:0] head_wb_data = '0;
   logic        head_mem_valid = 1'b0;
   logic [31:0] head_mem_addr = '0;
   logic        head_mem_we = 1'b0;
   logic [31:0] head_mem_wdata = '0;
   logic        wb_pending = 1'b0;
   logic        mem_pending = 1'b0;
   logic        wb_due = 1'b0;   // writeback expected in this cycle
   logic        mem_due = 1'b0;
   logic        exec_writes = 1'b0;  // instruction now in execute
   logic        exec_mem = 1'b0;
   logic        pipe_live = 1'b0;
   int          errors = 0;
   int          accepted_n = 0;
   int          wb_writes = 0;
   int          wb_pulses = 0;
   int          mem_accesses = 0;

   cpu_core uut (
      .clk, .rst, .stall, .instruction, .mem_rdata,
      .mem_cs_n, .mem_we, .mem_addr, .mem_wdata,
      .wb_we, .wb_addr, .wb_data
   );

   always #(clk_period / 2) clk = ~clk;

   always_comb mem_rdata = data_mem[mem_addr[9:2]];

   always @(posedge clk) begin
      if (!mem_cs_n && mem_we) data_mem[mem_addr[9:2]] <= mem_wdata;
   end

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h0bad_f00d;
   endfunction

   function automatic logic [4:0] pick_reg();
      return 5'($urandom % 8);  // few registers, many hazards
   endfunction

   function automatic logic [31:0] random_instruction();
      logic [3:0]  kind;
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
      kind = 4'($urandom % 12);
      rd   = pick_reg();
      rs   = pick_reg();
      rt   = pick_reg();
      imm  = 16'($urandom);
      case (kind)
         4'd0:       op = op_add;
         4'd1:       op = op_sub;
         4'd2:       op = op_and;
         4'd3:       op = op_or;
         4'd4:       op = op_xor;
         4'd5:       op = op_slt;
         4'd6, 4'd7: op = op_addi;
         4'd8, 4'd9: op = op_lw;
         4'd10:      op = op_sw;
         default:    op = op_nop;
      endcase
      if (op == op_nop) return 32'd0;
      if (kind < 4'd6) return {op, rd, rs, rt, 11'd0};
      return {op, rd, rs, imm};
   endfunction

   // reference execution at acceptance, queues what the result stage must show
   task automatic apply_instruction(input logic [31:0] instr);
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [31:0] value;
      logic        writes;
      op     = instr[31:26];
      rd     = instr[25:21];
      a      = model_regs[instr[20:16]];
      b      = model_regs[instr[15:11]];
      addr   = a + {{16{instr[15]}}, instr[15:0]};
      value  = '0;
      writes = 1'b1;
      exec_mem = 1'b0;
      case (op)
         op_add:  value = a + b;
         op_sub:  value = a - b;
         op_and:  value = a & b;
         op_or:   value = a | b;
         op_xor:  value = a ^ b;
         op_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         op_addi: value = addr;
         op_lw: begin
            value    = model_mem[addr[9:2]];
            exec_mem = 1'b1;
            exp_mem_addr.push_back(addr);
            exp_mem_we.push_back(1'b0);
            exp_mem_wdata.push_back(32'd0);
         end
         op_sw: begin
            writes   = 1'b0;
            exec_mem = 1'b1;
            model_mem[addr[9:2]] = model_regs[rd];
            exp_mem_addr.push_back(addr);
            exp_mem_we.push_back(1'b1);
            exp_mem_wdata.push_back(model_regs[rd]);
         end
         default: writes = 1'b0;
      endcase
      exec_writes = writes && rd != 5'd0;  // r0 writes are dropped
      if (exec_writes) begin
         model_regs[rd] = value;
         exp_wb_addr.push_back(rd);
         exp_wb_data.push_back(value);
         wb_writes++;
      end
   endtask

   // bookkeeping for the edge just taken, before new inputs are driven
   task automatic track_edge();
      if (wb_pending && exp_wb_addr.size() != 0) begin
         void'(exp_wb_addr.pop_front());
         void'(exp_wb_data.pop_front());
      end
      if (mem_pending && exp_mem_addr.size() != 0) begin
         void'(exp_mem_addr.pop_front());
         void'(exp_mem_we.pop_front());
         void'(exp_mem_wdata.pop_front());
      end
      if (wb_pending) wb_pulses++;
      if (mem_pending) mem_accesses++;
      if (!stall) begin
         wb_due  = exec_writes;  // older instruction moves to result
         mem_due = exec_mem;
         apply_instruction(instruction);
         accepted_n++;
         pipe_live = accepted_n >= 2;
      end else begin
         wb_due  = 1'b0;  // bubble
         mem_due = 1'b0;
      end
   endtask

   task automatic note_heads();
      wb_pending     = wb_we;
      mem_pending    = !mem_cs_n;
      head_wb_valid  = exp_wb_addr.size() != 0;
      head_mem_valid = exp_mem_addr.size() != 0;
      if (head_wb_valid) begin
         head_wb_addr = exp_wb_addr[0];
         head_wb_data = exp_wb_data[0];
      end
      if (head_mem_valid) begin
         head_mem_addr  = exp_mem_addr[0];
         head_mem_we    = exp_mem_we[0];
         head_mem_wdata = exp_mem_wdata[0];
      end
   endtask

   // everything is stable at the falling edge
   reset_idle: assert property (@(negedge clk)
      !pipe_live |-> (!wb_we && mem_cs_n && !mem_we))
      else begin
         errors++;
         $display("outputs active before the first instruction reached writeback");
      end

   wb_timing: assert property (@(negedge clk) disable iff (!rst) wb_we == wb_due)
      else begin
         errors++;
         $display("Fail wb_timing expected %b actual %b", wb_due, wb_we);
      end

   mem_timing: assert property (@(negedge clk) disable iff (!rst) !mem_cs_n == mem_due)
      else begin
         errors++;
         $display("Fail mem_timing expected %b actual %b", mem_due, !mem_cs_n);
      end

   stall_bubble: assert property (@(negedge clk) disable iff (!rst)
      stall |=> (!wb_we && mem_cs_n))
      else begin
         errors++;
         $display("result stage active in the bubble after a stall cycle");
      end

   wb_expected: assert property (@(negedge clk) disable iff (!rst) wb_we |-> head_wb_valid)
      else begin
         errors++;
         $display("writeback pulse with no instruction waiting for it");
      end

   wb_value: assert property (@(negedge clk) disable iff (!rst)
      (wb_we && head_wb_valid) |-> (wb_addr == head_wb_addr && wb_data == head_wb_data))
      else begin
         errors++;
         $display("Fail writeback expected r%0d=%h actual r%0d=%h",
                  head_wb_addr, head_wb_data, wb_addr, wb_data);
      end

   mem_expected: assert property (@(negedge clk) disable iff (!rst)
      !mem_cs_n |-> head_mem_valid)
      else begin
         errors++;
         $display("memory access with no load or store waiting for it");
      end

   mem_value: assert property (@(negedge clk) disable iff (!rst)
      (!mem_cs_n && head_mem_valid) |-> (mem_addr == head_mem_addr &&
         mem_we == head_mem_we && (!head_mem_we || mem_wdata == head_mem_wdata)))
      else begin
         errors++;
         $display("Fail memory_access expected addr=%h we=%b wdata=%h actual addr=%h we=%b wdata=%h",
                  head_mem_addr, head_mem_we, head_mem_wdata, mem_addr, mem_we, mem_wdata);
      end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("watchdog expired after %0d cycles", watchdog_cycles);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      void'($urandom(32'h7879148e));
      rst         = 1'b1;
      stall       = 1'b0;
      instruction = 32'd0;
      for (int i = 0; i < 256; i++) begin
         data_mem[i]  = fill_word({22'd0, 8'(i), 2'b00});
         model_mem[i] = fill_word({22'd0, 8'(i), 2'b00});
      end
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = 32'd0;
      end
      #1 rst = 1'b0;
      repeat (5) @(posedge clk);
      #drive_delay rst = 1'b1;

      while (accepted_n < n_instr + drain_cycles) begin
         @(posedge clk);
         #drive_delay;
         track_edge();
         if (!stall) begin  // previous word taken, fetch the next
            instruction = (accepted_n < n_instr) ? random_instruction() : 32'd0;
         end
         stall = (accepted_n < n_instr) ? (($urandom % 100) < 20) : 1'b0;
         note_heads();
      end

      queues_drained: assert (exp_wb_addr.size() == 0 && exp_mem_addr.size() == 0)
         else begin
            errors++;
            $display("%0d writebacks and %0d memory accesses never appeared",
                     exp_wb_addr.size(), exp_mem_addr.size());
         end
      pulse_count: assert (wb_pulses == wb_writes)
         else begin
            errors++;
            $display("Fail pulse_count expected %0d actual %0d", wb_writes, wb_pulses);
         end

      $display("checks done: %0d errors, %0d writebacks, %0d memory accesses",
               errors, wb_pulses, mem_accesses);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
